// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_udp_fragment_buffer
FILELIST    ?= udp_fragment_buffer.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_udp_fragment_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_fragment_buffer;

    localparam int FRAGMENT_COUNT = 9;

    // One row of the stimulus table
    typedef struct packed {
        frag_stream_pkg::frag_id_t id;
        logic [15:0]               length;
        logic [7:0]                pre_gap;
        logic [7:0]                gap_pattern;
        logic                      must_wait;
    } stimulus_t;

    // One byte the output should carry
    typedef struct packed {
        frag_stream_pkg::out_beat_t beat;
        logic                       last;
        logic [7:0]                 index;
    } expect_t;

    // id, length, idle cycles before, idle cycle after byte n when bit n%8 is set, in_ready wait
    localparam stimulus_t STIMULUS [FRAGMENT_COUNT] = '{
        '{16'h1a01, 16'd5,  8'd0,  8'h00, 1'b0},
        '{16'h2b02, 16'd9,  8'd4,  8'ha5, 1'b0},
        '{16'h2b03, 16'd6,  8'd2,  8'h06, 1'b0},
        '{16'h2b04, 16'd4,  8'd3,  8'h01, 1'b0},
        '{16'h3c05, 16'd48, 8'd20, 8'h00, 1'b0},
        '{16'h3c06, 16'd3,  8'd0,  8'h00, 1'b0},
        '{16'h3c07, 16'd2,  8'd0,  8'h00, 1'b0},
        '{16'h3c08, 16'd4,  8'd0,  8'h00, 1'b0},
        '{16'h4d09, 16'd7,  8'd0,  8'h12, 1'b1}
    };

    logic                       clock;
    logic                       reset_n;
    frag_stream_pkg::in_beat_t  in_beat;
    logic                       in_ready;
    frag_stream_pkg::out_beat_t out_beat;

    expect_t     expected [$];
    expect_t     seen;
    logic [31:0] lfsr_state;
    int          error_count;
    int          reported_errors;
    int          bytes_sent;
    int          bytes_seen;
    int          fragments_done;

    udp_fragment_buffer u_dut (
        .clock    (clock),
        .reset_n  (reset_n),
        .in_beat  (in_beat),
        .in_ready (in_ready),
        .out_beat (out_beat)
    );

    always #10 clock = ~clock;

    ////////////////////////////////
    // Helpers
    ////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_byte(output frag_stream_pkg::byte_t value);
        int k;
        value = '0;
        for (k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int watchdog_cycles();
        int i;
        int total;
        total = 0;
        for (i = 0; i < FRAGMENT_COUNT; i++) begin
            total += int'(STIMULUS[i].pre_gap) + 2 * int'(STIMULUS[i].length);
        end
        return total * 4 + 200;
    endfunction

    // Upper bound for the output to finish once the input is done
    function automatic int drain_limit_cycles();
        int i;
        int total;
        total = 0;
        for (i = 0; i < FRAGMENT_COUNT; i++) begin
            total += int'(STIMULUS[i].length);
        end
        return total + 100;
    endfunction

    task automatic check_byte(input string name, input frag_stream_pkg::byte_t actual,
                              input frag_stream_pkg::byte_t wanted);
        if (actual !== wanted) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, wanted);
            error_count++;
        end
    endtask

    task automatic check_id(input string name, input frag_stream_pkg::frag_id_t actual,
                            input frag_stream_pkg::frag_id_t wanted);
        if (actual !== wanted) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, wanted);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic wanted);
        if (actual !== wanted) begin
            $display("error at %0d ns: %s is %b, expected %b", $time, name, actual, wanted);
            error_count++;
        end
    endtask

    task automatic drive_idle_cycle();
        @(posedge clock);
        #2;
        in_beat = '0;
    endtask

    task automatic report_fragment(input int row);
        fragments_done++;
        $display("fragment %0d id %h, %0d bytes: %s", row, STIMULUS[row].id,
                 STIMULUS[row].length, (error_count == reported_errors) ? "pass" : "fail");
        reported_errors = error_count;
    endtask

    task automatic send_fragment(input int row);
        stimulus_t              entry;
        frag_stream_pkg::byte_t value;
        int                     length;
        int                     waited;
        int                     b;
        entry  = STIMULUS[row];
        length = int'(entry.length);
        waited = 0;
        repeat (entry.pre_gap) drive_idle_cycle();
        drive_idle_cycle();
        // Next slot may still hold an earlier fragment
        while (!in_ready) begin
            waited++;
            drive_idle_cycle();
        end
        check_flag("in_ready wait", waited != 0, entry.must_wait);
        for (b = 0; b < length; b++) begin
            if (b != 0) begin
                drive_idle_cycle();
                if (entry.gap_pattern[3'(b - 1)]) begin
                    drive_idle_cycle();
                end
            end
            random_byte(value);
            in_beat = '{enable: 1'b1, last: (b == length - 1), id: entry.id, data: value};
            expected.push_back('{
                beat:  '{valid: 1'b1, first: (b == 0), packet_id: entry.id, data: value},
                last:  (b == length - 1),
                index: 8'(row)
            });
            bytes_sent++;
        end
    endtask

    ////////////////////////////////
    // Output monitor
    ////////////////////////////////

    always @(negedge clock) begin
        if (reset_n && out_beat.valid) begin
            if (expected.size() == 0) begin
                $display("output beat with data %h and id %h at %0d ns was not expected",
                         out_beat.data, out_beat.packet_id, $time);
                error_count++;
            end else begin
                seen = expected.pop_front();
                check_byte("out_beat.data", out_beat.data, seen.beat.data);
                check_flag("out_beat.first", out_beat.first, seen.beat.first);
                check_id("out_beat.packet_id", out_beat.packet_id, seen.beat.packet_id);
                bytes_seen++;
                if (seen.last) begin
                    report_fragment(int'(seen.index));
                end
            end
        end
    end

    initial begin : main
        int row;
        int drain_cycles;
        int drain_limit;
        clock           = 1'b0;
        reset_n         = 1'b0;
        in_beat         = '0;
        lfsr_state      = 32'h9d33;
        error_count     = 0;
        reported_errors = 0;
        bytes_sent      = 0;
        bytes_seen      = 0;
        fragments_done  = 0;
        repeat (3) @(posedge clock);
        #2;
        reset_n = 1'b1;
        drive_idle_cycle();
        // Slot 0 idle and nothing stored yet
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_beat.valid", out_beat.valid, 1'b0);
        for (row = 0; row < FRAGMENT_COUNT; row++) begin
            send_fragment(row);
        end
        drive_idle_cycle();
        drain_limit  = drain_limit_cycles();
        drain_cycles = 0;
        while (expected.size() != 0 && drain_cycles < drain_limit) begin
            @(posedge clock);
            drain_cycles++;
        end
        // Room for stray beats after the last expected byte
        repeat (20) @(posedge clock);
        if (fragments_done != FRAGMENT_COUNT) begin
            $display("only %0d of %0d fragments came out whole", fragments_done, FRAGMENT_COUNT);
            error_count++;
        end
        if (bytes_seen != bytes_sent) begin
            $display("sent %0d bytes but saw %0d at the output", bytes_sent, bytes_seen);
            error_count++;
        end
        $display("fragments %0d, bytes sent %0d, bytes seen %0d, errors %0d",
                 fragments_done, bytes_sent, bytes_seen, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clock);
        $display("timeout after %0d cycles, the output stream never finished", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/frag_slot_pkg.sv ====
`default_nettype none

package frag_slot_pkg;

    localparam int unsigned SLOT_COUNT       = 4;
    localparam int unsigned SLOT_FIFO_DEPTH  = 2048;
    localparam int unsigned SLOT_INDEX_WIDTH = $clog2(SLOT_COUNT);

    // Selects one slot
    typedef logic [SLOT_INDEX_WIDTH-1:0] slot_index_t;

    // Stored FIFO word with the flag set on the first byte of a fragment
    typedef struct packed {
        logic                  first;
        frag_stream_pkg::byte_t data;
    } slot_word_t;

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_CAPTURE,
        SLOT_DRAIN
    } slot_state_t;

    // Round-robin step that wraps after the last slot
    function automatic slot_index_t next_slot(slot_index_t index);
        return (index == slot_index_t'(SLOT_COUNT - 1)) ? '0 : index + 1'b1;
    endfunction

endpackage

`default_nettype wire

// ==== hw/frag_stream_pkg.sv ====
`default_nettype none

package frag_stream_pkg;

    ////////////////////////////////
    // Basic stream fields
    ////////////////////////////////

    // One payload byte
    typedef logic [7:0] byte_t;

    // IP identification field of a fragment
    typedef logic [15:0] frag_id_t;

    ////////////////////////////////
    // Beats at the subsystem edge
    ////////////////////////////////

    // Input beat with an id that stays constant over a fragment
    typedef struct packed {
        logic     enable;
        logic     last;
        frag_id_t id;
        byte_t    data;
    } in_beat_t;

    // Output beat where first marks the start of a fragment
    typedef struct packed {
        logic     valid;
        logic     first;
        frag_id_t packet_id;
        byte_t    data;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== hw/fragment_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module fragment_dispatcher (
    input  logic                                clock,
    input  logic                                reset_n,
    input  frag_stream_pkg::in_beat_t           in_beat,
    input  logic [frag_slot_pkg::SLOT_COUNT-1:0] slot_ready,

    output logic                                in_ready,
    output frag_stream_pkg::in_beat_t           slot_beat,
    output logic [frag_slot_pkg::SLOT_COUNT-1:0] slot_select
);

    frag_slot_pkg::slot_index_t            slot_pointer;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]  select_next;
    logic                                  fragment_busy;
    logic                                  beat_enable;
    logic                                  beat_last;
    frag_stream_pkg::frag_id_t             beat_id;
    frag_stream_pkg::byte_t                beat_data;

    // New fragment only at an idle slot and between fragments
    assign in_ready = slot_ready[slot_pointer] && !fragment_busy;

    // Select is registered with the beat so the pointer can move early
    always_comb begin
        select_next               = '0;
        select_next[slot_pointer] = 1'b1;
    end

    ////////////////////////////////
    // Pointer and beat control
    ////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slot_pointer  <= '0;
            fragment_busy <= 1'b0;
            beat_enable   <= 1'b0;
            beat_last     <= 1'b0;
            slot_select   <= '0;
        end else begin
            beat_enable <= in_beat.enable;
            beat_last   <= in_beat.last;
            slot_select <= select_next;
            if (in_beat.enable) begin
                fragment_busy <= !in_beat.last;
            end
            // Next fragment lands in the next slot once the last beat goes out
            if (in_beat.enable && in_beat.last) begin
                slot_pointer <= frag_slot_pkg::next_slot(slot_pointer);
            end
        end
    end

    always_ff @(posedge clock) begin
        beat_id   <= in_beat.id;
        beat_data <= in_beat.data;
    end

    assign slot_beat = '{enable: beat_enable, last: beat_last, id: beat_id, data: beat_data};

endmodule

`default_nettype wire

// ==== hw/slot_drainer.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_drainer (
    input  logic                                                       clock,
    input  logic                                                       reset_n,
    input  logic [frag_slot_pkg::SLOT_COUNT-1:0]                       data_ready,
    input  frag_slot_pkg::slot_word_t [frag_slot_pkg::SLOT_COUNT-1:0]  push_data,
    input  logic [frag_slot_pkg::SLOT_COUNT-1:0]                       push_data_valid,
    input  frag_stream_pkg::frag_id_t [frag_slot_pkg::SLOT_COUNT-1:0]  current_packet_id,

    output logic [frag_slot_pkg::SLOT_COUNT-1:0]                       push_data_enable,
    output frag_stream_pkg::out_beat_t                                 out_beat
);

    frag_slot_pkg::slot_index_t slot_pointer;
    logic                       previous_ready;
    logic                       current_ready;
    logic                       take_word;
    logic                       ready_fell;
    logic                       out_valid;
    frag_slot_pkg::slot_word_t  out_word;
    frag_stream_pkg::frag_id_t  out_packet_id;

    assign current_ready = data_ready[slot_pointer];

    // Read only from the current slot, and only while it is draining
    always_comb begin
        push_data_enable               = '0;
        push_data_enable[slot_pointer] = current_ready;
    end

    assign take_word  = current_ready && push_data_valid[slot_pointer];

    // Slot is empty and back to idle
    assign ready_fell = previous_ready && !current_ready;

    ////////////////////////////////
    // Slot pointer
    ////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slot_pointer   <= '0;
            previous_ready <= 1'b0;
            out_valid      <= 1'b0;
        end else begin
            out_valid <= take_word;
            if (ready_fell) begin
                slot_pointer   <= frag_slot_pkg::next_slot(slot_pointer);
                // New slot starts without history
                previous_ready <= 1'b0;
            end else begin
                previous_ready <= current_ready;
            end
        end
    end

    ////////////////////////////////
    // Output register
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (take_word) begin
            out_word      <= push_data[slot_pointer];
            out_packet_id <= current_packet_id[slot_pointer];
        end
    end

    assign out_beat = '{
        valid:     out_valid,
        first:     out_word.first,
        packet_id: out_packet_id,
        data:      out_word.data
    };

endmodule

`default_nettype wire

// ==== hw/synchronous_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module synchronous_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DATA_DEPTH = 16
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [DATA_WIDTH-1:0] write_data,

    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_data_valid,
    output logic                  full,
    output logic                  empty
);

    localparam int ADDR_WIDTH = $clog2(DATA_DEPTH);

    logic [DATA_WIDTH-1:0] memory [DATA_DEPTH];
    logic [ADDR_WIDTH-1:0] write_pointer;
    logic [ADDR_WIDTH-1:0] read_pointer;
    logic [ADDR_WIDTH:0]   word_count;
    logic                  do_write;
    logic                  do_read;

    // Wraps at the depth, so a depth that is not a power of two works too
    function automatic logic [ADDR_WIDTH-1:0] advance(logic [ADDR_WIDTH-1:0] pointer);
        return (pointer == ADDR_WIDTH'(DATA_DEPTH - 1)) ? '0 : pointer + 1'b1;
    endfunction

    assign full  = (word_count == (ADDR_WIDTH + 1)'(DATA_DEPTH));
    assign empty = (word_count == '0);

    // Overflow and underflow requests are dropped
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    // Head word shows without a read request
    assign read_data       = memory[read_pointer];
    assign read_data_valid = !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            word_count    <= '0;
        end else begin
            if (do_write) begin
                write_pointer <= advance(write_pointer);
            end
            if (do_read) begin
                read_pointer <= advance(read_pointer);
            end
            // Simultaneous read and write leaves the count alone
            if (do_write && !do_read) begin
                word_count <= word_count + 1'b1;
            end else if (do_read && !do_write) begin
                word_count <= word_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/udp_fragment_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_fragment_buffer (
    input  logic                       clock,
    input  logic                       reset_n,
    input  frag_stream_pkg::in_beat_t  in_beat,

    output logic                       in_ready,
    output frag_stream_pkg::out_beat_t out_beat
);

    frag_stream_pkg::in_beat_t                                        slot_beat;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]                             slot_select;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]                             slot_ready;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]                             data_ready;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]                             push_data_valid;
    logic [frag_slot_pkg::SLOT_COUNT-1:0]                             push_data_enable;
    frag_slot_pkg::slot_word_t [frag_slot_pkg::SLOT_COUNT-1:0]        push_data;
    frag_stream_pkg::frag_id_t [frag_slot_pkg::SLOT_COUNT-1:0]        current_packet_id;

    fragment_dispatcher u_dispatcher (
        .clock       (clock),
        .reset_n     (reset_n),
        .in_beat     (in_beat),
        .slot_ready  (slot_ready),
        .in_ready    (in_ready),
        .slot_beat   (slot_beat),
        .slot_select (slot_select)
    );

    for (genvar i = 0; i < frag_slot_pkg::SLOT_COUNT; i++) begin : g_slot
        // Only the selected slot sees the strobes
        logic slot_enable;
        logic slot_last;

        assign slot_enable = slot_beat.enable & slot_select[i];
        assign slot_last   = slot_beat.last & slot_select[i];

        udp_fragment_slot u_slot (
            .clock             (clock),
            .reset_n           (reset_n),
            .data              (slot_beat.data),
            .data_enable       (slot_enable),
            .data_last         (slot_last),
            .fragment_id       (slot_beat.id),
            .push_data_enable  (push_data_enable[i]),
            .ready             (slot_ready[i]),
            .data_ready        (data_ready[i]),
            .push_data         (push_data[i]),
            .push_data_valid   (push_data_valid[i]),
            .current_packet_id (current_packet_id[i])
        );
    end

    slot_drainer u_drainer (
        .clock             (clock),
        .reset_n           (reset_n),
        .data_ready        (data_ready),
        .push_data         (push_data),
        .push_data_valid   (push_data_valid),
        .current_packet_id (current_packet_id),
        .push_data_enable  (push_data_enable),
        .out_beat          (out_beat)
    );

endmodule

`default_nettype wire

// ==== hw/udp_fragment_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_fragment_slot (
    input  logic                      clock,
    input  logic                      reset_n,
    input  frag_stream_pkg::byte_t    data,
    input  logic                      data_enable,
    input  logic                      data_last,
    input  frag_stream_pkg::frag_id_t fragment_id,
    input  logic                      push_data_enable,

    output logic                      ready,
    output logic                      data_ready,
    output frag_slot_pkg::slot_word_t push_data,
    output logic                      push_data_valid,
    output frag_stream_pkg::frag_id_t current_packet_id
);

    frag_slot_pkg::slot_state_t state;
    frag_slot_pkg::slot_state_t state_next;
    logic                       ready_next;
    logic                       data_ready_next;
    frag_stream_pkg::frag_id_t  packet_id_next;
    frag_slot_pkg::slot_word_t  buffer_word;
    frag_slot_pkg::slot_word_t  buffer_word_next;
    logic                       buffer_valid;
    logic                       buffer_valid_next;
    logic                       fifo_empty;

    synchronous_fifo #(
        .DATA_WIDTH ($bits(frag_slot_pkg::slot_word_t)),
        .DATA_DEPTH (frag_slot_pkg::SLOT_FIFO_DEPTH)
    ) fragment_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .read_enable     (push_data_enable),
        .write_enable    (buffer_valid),
        .write_data      (buffer_word),
        .read_data       (push_data),
        .read_data_valid (push_data_valid),
        .full            (),
        .empty           (fifo_empty)
    );

    ////////////////////////////////
    // Slot FSM
    ////////////////////////////////

    always_comb begin
        state_next        = state;
        ready_next        = 1'b0;
        data_ready_next   = 1'b0;
        packet_id_next    = current_packet_id;
        buffer_word_next  = buffer_word;
        buffer_valid_next = 1'b0;

        case (state)
            frag_slot_pkg::SLOT_IDLE: begin
                ready_next     = !data_enable;
                packet_id_next = '0;
                if (data_enable) begin
                    state_next        = frag_slot_pkg::SLOT_CAPTURE;
                    packet_id_next    = fragment_id;
                    buffer_word_next  = '{first: 1'b1, data: data};
                    buffer_valid_next = 1'b1;
                end
            end
            frag_slot_pkg::SLOT_CAPTURE: begin
                if (data_enable) begin
                    buffer_word_next  = '{first: 1'b0, data: data};
                    buffer_valid_next = 1'b1;
                end
                // FIFO already holds the first byte, so draining can start now
                if (data_last) begin
                    state_next      = frag_slot_pkg::SLOT_DRAIN;
                    data_ready_next = 1'b1;
                end
            end
            frag_slot_pkg::SLOT_DRAIN: begin
                data_ready_next = !fifo_empty;
                if (fifo_empty) begin
                    state_next = frag_slot_pkg::SLOT_IDLE;
                end
            end
            default: begin
                state_next = frag_slot_pkg::SLOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= frag_slot_pkg::SLOT_IDLE;
            ready             <= 1'b0;
            data_ready        <= 1'b0;
            current_packet_id <= '0;
            buffer_valid      <= 1'b0;
        end else begin
            state             <= state_next;
            ready             <= ready_next;
            data_ready        <= data_ready_next;
            current_packet_id <= packet_id_next;
            buffer_valid      <= buffer_valid_next;
        end
    end

    always_ff @(posedge clock) begin
        buffer_word <= buffer_word_next;
    end

endmodule

`default_nettype wire

// ==== udp_fragment_buffer.f ====
hw/frag_stream_pkg.sv
hw/frag_slot_pkg.sv
hw/synchronous_fifo.sv
hw/fragment_dispatcher.sv
hw/udp_fragment_slot.sv
hw/slot_drainer.sv
hw/udp_fragment_buffer.sv
dv/tb_udp_fragment_buffer.sv
